// ==== src.f ====
+incdir+include
rtl/tile_pkg.sv
rtl/mini_core.sv
rtl/du_apb.sv
rtl/trace_fifo.sv
rtl/core_tile.sv
tb/tb_wb_mem.sv
tb/tb_core_tile.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tile testbench with Verilator, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_core_tile -o tb_sim \
   > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== tb/tb_core_tile.sv ====
`timescale 1ns/1ns
`include "tile_defines.svh"

module tb_core_tile;

   import tile_pkg::*;

   logic clk_i = 1'b0;
   logic rst_i;
   logic iwb_cyc_o, iwb_stb_o, iwb_ack_i, dwb_cyc_o, dwb_stb_o, dwb_we_o, dwb_ack_i;
   logic [31:0] iwb_adr_o, iwb_dat_i, dwb_adr_o, dwb_dat_o, dwb_dat_i;
   logic apb_psel_i, apb_penable_i, apb_pwrite_i, apb_pready_o, apb_pslverr_o;
   logic [11:0] apb_paddr_i;
   logic [31:0] apb_pwdata_i, apb_prdata_o;
   logic trace_ready_i, trace_valid_o;
   logic [`TRACE_EXEC_WIDTH-1:0] trace_o;

   logic [31:0] mreg [8];          // Model registers
   logic [31:0] mdata [256];       // Model memory, program included
   logic [31:0] mpc;
   logic [31:0] rand_state;
   logic [31:0] prog [13];         // Program table
   logic [31:0] first_wb [9];      // Expected wbdata of the straight-line part
   int mismatch_count = 0;
   int fail_count = 0;
   int rec_count = 0;

   always #2 clk_i = ~clk_i;

   core_tile u_dut (.*);

   tb_wb_mem u_mem (
      .clk_i(clk_i), .rst_i(rst_i),
      .iwb_cyc_i(iwb_cyc_o), .iwb_stb_i(iwb_stb_o), .iwb_adr_i(iwb_adr_o),
      .iwb_ack_o(iwb_ack_i), .iwb_dat_o(iwb_dat_i),
      .dwb_cyc_i(dwb_cyc_o), .dwb_stb_i(dwb_stb_o), .dwb_we_i(dwb_we_o),
      .dwb_adr_i(dwb_adr_o), .dwb_dat_i(dwb_dat_o),
      .dwb_ack_o(dwb_ack_i), .dwb_dat_o(dwb_dat_i)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] ra, input logic [2:0] rb,
                                          input logic [15:0] imm);
      return {op, rd, ra, rb, 3'b000, imm};
   endfunction

   function automatic logic [31:0] fill_word(input int idx);
      return {4'hf, 20'h5a5a5, 8'(idx)};  // NOP opcode, word index in low byte
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got) begin
         $display("Mismatch %s exp %h got %h", name, exp, got);
         mismatch_count++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Testbench failed");
      $finish;
   endtask

   // Step the ISA model for one retired instruction and compare the trace vector
   task automatic check_record();
      logic [31:0] insn, imm, a, b, nxt, exp_data;
      logic        exp_wben;
      logic [2:0]  rd, ra, rb;
      insn     = mdata[mpc[9:2]];
      rd       = insn[`INSN_RD_MSB:`INSN_RD_LSB];
      ra       = insn[`INSN_RA_MSB:`INSN_RA_LSB];
      rb       = insn[`INSN_RB_MSB:`INSN_RB_LSB];
      imm      = {{16{insn[15]}}, insn[15:0]};
      a        = mreg[ra];
      b        = mreg[rb];
      nxt      = mpc + 32'd4;
      exp_wben = 1'b0;
      exp_data = '0;
      case (opcode_e'(insn[`INSN_OP_MSB:`INSN_OP_LSB]))
         ADDI: begin
            exp_wben = 1'b1;
            exp_data = a + imm;
         end
         ADD: begin
            exp_wben = 1'b1;
            exp_data = a + b;
         end
         SUB: begin
            exp_wben = 1'b1;
            exp_data = a - b;
         end
         LW: begin
            exp_wben = 1'b1;
            exp_data = mdata[8'((a + imm) >> 2)];
         end
         SW:   mdata[8'((a + imm) >> 2)] = b;
         BNE:  if (a != b) nxt = mpc + (imm << 2);
         default: begin
         end                                             // NOP
      endcase
      if (trace_o[`TRACE_EXEC_ENABLE_MSB] !== 1'b1) begin
         $display("Mismatch trace_enable exp 1 got %h", trace_o[`TRACE_EXEC_ENABLE_MSB]);
         mismatch_count++;
      end
      compare("trace_pc", mpc, trace_o[`TRACE_EXEC_PC_MSB:`TRACE_EXEC_PC_LSB]);
      compare("trace_insn", insn, trace_o[`TRACE_EXEC_INSN_MSB:`TRACE_EXEC_INSN_LSB]);
      compare("trace_wben", 32'(exp_wben), 32'(trace_o[`TRACE_EXEC_WBEN_MSB]));
      if (exp_wben) begin
         compare("trace_wbreg", 32'(rd), 32'(trace_o[`TRACE_EXEC_WBREG_MSB:`TRACE_EXEC_WBREG_LSB]));
         compare("trace_wbdata", exp_data, trace_o[`TRACE_EXEC_WBDATA_MSB:`TRACE_EXEC_WBDATA_LSB]);
         if (rec_count < 9) compare("first_pass_wbdata", first_wb[rec_count], exp_data);
      end
      if (exp_wben && rd != 3'd0) mreg[rd] = exp_data;    // r0 stays zero
      mpc = nxt;
      rec_count++;
   endtask

   // One falling edge, random trace back-pressure, record taken at the next rising edge
   task automatic tick();
      @(negedge clk_i);
      rand_state    = lcg_next(rand_state);
      trace_ready_i = (rand_state[18:16] == 3'b000);   // Sparse pops let the FIFO fill
      if (trace_ready_i && trace_valid_o && !rst_i) check_record();
   endtask

   task automatic wait_records(input int n);
      int t;
      t = 0;
      while (rec_count < n && t < 3000) begin
         tick();
         t++;
      end
      if (rec_count < n) report_timeout("trace records");
   endtask

   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic slverr);
      int t;
      t = 0;
      tick();
      apb_psel_i    = 1'b1;                          // Setup phase
      apb_penable_i = 1'b0;
      apb_pwrite_i  = wr;
      apb_paddr_i   = addr;
      apb_pwdata_i  = wdata;
      tick();
      apb_penable_i = 1'b1;
      #1;
      while (!apb_pready_o && t < 50) begin           // Wait states
         tick();
         #1;
         t++;
      end
      if (!apb_pready_o) report_timeout("APB pready");
      rdata  = apb_prdata_o;
      slverr = apb_pslverr_o;
      tick();
      apb_psel_i    = 1'b0;
      apb_penable_i = 1'b0;
   endtask

   initial begin
      logic [31:0] rd;
      logic        err;
      int          t;
      rst_i = 1'b1;
      apb_psel_i = 1'b0;
      apb_penable_i = 1'b0;
      apb_pwrite_i = 1'b0;
      apb_paddr_i = '0;
      apb_pwdata_i = '0;
      trace_ready_i = 1'b0;
      rand_state = 32'h892b_647c;
      mpc = '0;
      prog[0]  = encode(ADDI, 3'd1, 3'd0, 3'd0, 16'd5);
      prog[1]  = encode(ADDI, 3'd2, 3'd0, 3'd0, 16'hfffd);
      prog[2]  = encode(ADD,  3'd3, 3'd1, 3'd2, 16'd0);
      prog[3]  = encode(SUB,  3'd4, 3'd1, 3'd2, 16'd0);
      prog[4]  = encode(ADDI, 3'd0, 3'd1, 3'd0, 16'd7);   // Write to r0 discarded
      prog[5]  = encode(ADDI, 3'd5, 3'd0, 3'd0, 16'h0080);
      prog[6]  = encode(SW,   3'd0, 3'd5, 3'd4, 16'd8);
      prog[7]  = encode(LW,   3'd6, 3'd5, 3'd0, 16'd8);
      prog[8]  = encode(ADDI, 3'd7, 3'd0, 3'd0, 16'd3);
      prog[9]  = encode(ADDI, 3'd7, 3'd7, 3'd0, 16'hffff); // Countdown loop
      prog[10] = encode(BNE,  3'd0, 3'd7, 3'd0, 16'hffff);
      prog[11] = encode(ADD,  3'd1, 3'd1, 3'd6, 16'd0);
      prog[12] = encode(BNE,  3'd0, 3'd1, 3'd0, 16'd0);    // Spin on itself
      first_wb = '{32'd5, 32'hffff_fffd, 32'd2, 32'd8, 32'd12, 32'h80, 32'd0, 32'd8, 32'd3};
      for (int i = 0; i < 8; i++) mreg[i] = '0;
      for (int i = 0; i < 256; i++) mdata[i] = fill_word(i);
      for (int i = 0; i < 13; i++) mdata[i] = prog[i];
      for (int i = 0; i < 256; i++) u_mem.mem[i] = mdata[i];
      repeat (10) @(negedge clk_i);
      if (iwb_cyc_o || iwb_stb_o || dwb_cyc_o || dwb_stb_o || trace_valid_o) begin
         $display("Bus request or trace valid active during reset");
         fail_count++;
      end
      rst_i = 1'b0;

      wait_records(22);                               // ALU, memory, loop, spin
      compare("mem_0x88", 32'd8, u_mem.mem[34]);

      apb_xfer(1'b0, 12'h004, '0, rd, err);           // GPR read while running
      compare("apb_pslverr_running", 32'd1, 32'(err));
      apb_xfer(1'b0, 12'h200, '0, rd, err);           // Unmapped
      compare("apb_pslverr_unmapped", 32'd1, 32'(err));

      apb_xfer(1'b1, `DBG_ADR_CTRL, 32'd1, rd, err);  // Request stall
      t = 0;
      rd = '0;
      while (!rd[0] && t < 100) begin
         apb_xfer(1'b0, `DBG_ADR_CTRL, '0, rd, err);
         t++;
      end
      if (!rd[0]) report_timeout("core halt");
      t = 0;
      while (trace_valid_o && t < 200) begin          // Drain FIFO into the model
         tick();
         t++;
      end
      if (trace_valid_o) report_timeout("trace drain");
      for (int i = 1; i < 8; i++) begin
         apb_xfer(1'b0, 12'(4 * i), '0, rd, err);
         compare($sformatf("gpr%0d", i), mreg[i], rd);
         compare("apb_pslverr_gpr", 32'd0, 32'(err));
      end
      apb_xfer(1'b0, `DBG_ADR_PC, '0, rd, err);
      compare("pc", mpc, rd);
      apb_xfer(1'b1, 12'h01c, 32'd2, rd, err);        // r7 = 2
      mreg[7] = 32'd2;
      apb_xfer(1'b1, `DBG_ADR_PC, 32'd36, rd, err);   // Back to loop body
      mpc = 32'd36;
      apb_xfer(1'b0, 12'h01c, '0, rd, err);
      compare("gpr7_readback", 32'd2, rd);
      apb_xfer(1'b1, `DBG_ADR_CTRL, 32'd0, rd, err);  // Release stall
      wait_records(rec_count + 10);

      $display("Errors: %0d mismatches, %0d other failures, %0d records checked",
               mismatch_count, fail_count, rec_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== tb/tb_wb_mem.sv ====
`timescale 1ns/1ns

module tb_wb_mem (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        iwb_cyc_i,
   input  logic        iwb_stb_i,
   input  logic [31:0] iwb_adr_i,
   output logic        iwb_ack_o,
   output logic [31:0] iwb_dat_o,
   input  logic        dwb_cyc_i,
   input  logic        dwb_stb_i,
   input  logic        dwb_we_i,
   input  logic [31:0] dwb_adr_i,
   input  logic [31:0] dwb_dat_i,
   output logic        dwb_ack_o,
   output logic [31:0] dwb_dat_o
);

   logic [31:0] mem [256];      // Shared by both buses, loaded by the testbench
   logic [31:0] seed;
   logic        i_busy;
   logic        d_busy;
   logic [1:0]  i_cnt;          // Remaining wait cycles
   logic [1:0]  d_cnt;

   function automatic logic [31:0] advance_seed(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Outputs change on the falling edge only
   always @(negedge clk_i) begin
      if (rst_i) begin
         seed      <= 32'h892b_647c;
         i_busy    <= 1'b0;
         d_busy    <= 1'b0;
         i_cnt     <= 2'd0;
         d_cnt     <= 2'd0;
         iwb_ack_o <= 1'b0;
         dwb_ack_o <= 1'b0;
         iwb_dat_o <= '0;
         dwb_dat_o <= '0;
      end else begin
         seed <= advance_seed(seed);
         if (iwb_ack_o) begin
            iwb_ack_o <= 1'b0;                    // Single cycle ack
         end else if (iwb_cyc_i && iwb_stb_i) begin
            if (!i_busy) begin
               i_busy <= 1'b1;
               i_cnt  <= seed[25:24];             // Random 0..3 wait
            end else if (i_cnt == 2'd0) begin
               iwb_ack_o <= 1'b1;
               iwb_dat_o <= mem[iwb_adr_i[9:2]];
               i_busy    <= 1'b0;
            end else begin
               i_cnt <= i_cnt - 2'd1;
            end
         end
         if (dwb_ack_o) begin
            dwb_ack_o <= 1'b0;
         end else if (dwb_cyc_i && dwb_stb_i) begin
            if (!d_busy) begin
               d_busy <= 1'b1;
               d_cnt  <= seed[21:20];
            end else if (d_cnt == 2'd0) begin
               dwb_ack_o <= 1'b1;
               dwb_dat_o <= mem[dwb_adr_i[9:2]];
               d_busy    <= 1'b0;
               if (dwb_we_i) begin
                  mem[dwb_adr_i[9:2]] = dwb_dat_i;  // Store lands with the ack
               end
            end else begin
               d_cnt <= d_cnt - 2'd1;
            end
         end
      end
   end

endmodule

// ==== rtl/core_tile.sv ====
`timescale 1ns/1ns
`include "tile_defines.svh"

module core_tile (
   input  logic                         clk_i,
   input  logic                         rst_i,
   // Instruction Wishbone
   output logic                         iwb_cyc_o,
   output logic                         iwb_stb_o,
   output logic [31:0]                  iwb_adr_o,
   input  logic                         iwb_ack_i,
   input  logic [31:0]                  iwb_dat_i,
   // Data Wishbone
   output logic                         dwb_cyc_o,
   output logic                         dwb_stb_o,
   output logic                         dwb_we_o,
   output logic [31:0]                  dwb_adr_o,
   output logic [31:0]                  dwb_dat_o,
   input  logic                         dwb_ack_i,
   input  logic [31:0]                  dwb_dat_i,
   // APB debug access
   input  logic                         apb_psel_i,
   input  logic                         apb_penable_i,
   input  logic                         apb_pwrite_i,
   input  logic [11:0]                  apb_paddr_i,
   input  logic [31:0]                  apb_pwdata_i,
   output logic [31:0]                  apb_prdata_o,
   output logic                         apb_pready_o,
   output logic                         apb_pslverr_o,
   // Execution trace
   input  logic                         trace_ready_i,
   output logic                         trace_valid_o,
   output logic [`TRACE_EXEC_WIDTH-1:0] trace_o
);

   import tile_pkg::*;

   logic        du_stb;
   logic        du_we;
   logic [3:0]  du_adr;
   logic [31:0] du_dat_to_cpu;
   logic [31:0] du_dat_from_cpu;
   logic        du_ack;
   logic        du_stall;
   logic        du_halted;
   logic        push_valid;
   logic        push_ready;
   trace_rec_t  push_rec;
   trace_rec_t  trace_rec;   // FIFO head

   mini_core u_cpu (
      .clk_i(clk_i), .rst_i(rst_i),
      .iwb_cyc_o(iwb_cyc_o), .iwb_stb_o(iwb_stb_o), .iwb_adr_o(iwb_adr_o),
      .iwb_ack_i(iwb_ack_i), .iwb_dat_i(iwb_dat_i),
      .dwb_cyc_o(dwb_cyc_o), .dwb_stb_o(dwb_stb_o), .dwb_we_o(dwb_we_o),
      .dwb_adr_o(dwb_adr_o), .dwb_dat_o(dwb_dat_o),
      .dwb_ack_i(dwb_ack_i), .dwb_dat_i(dwb_dat_i),
      .du_stb_i(du_stb), .du_we_i(du_we), .du_adr_i(du_adr), .du_dat_i(du_dat_to_cpu),
      .du_stall_i(du_stall), .du_dat_o(du_dat_from_cpu), .du_ack_o(du_ack),
      .du_halted_o(du_halted),
      .push_valid_o(push_valid), .push_rec_o(push_rec), .push_ready_i(push_ready)
   );

   du_apb u_du (
      .clk_i(clk_i), .rst_i(rst_i),
      .apb_psel_i(apb_psel_i), .apb_penable_i(apb_penable_i), .apb_pwrite_i(apb_pwrite_i),
      .apb_paddr_i(apb_paddr_i), .apb_pwdata_i(apb_pwdata_i),
      .apb_prdata_o(apb_prdata_o), .apb_pready_o(apb_pready_o),
      .apb_pslverr_o(apb_pslverr_o),
      .du_dat_i(du_dat_from_cpu), .du_ack_i(du_ack), .du_halted_i(du_halted),
      .du_stb_o(du_stb), .du_we_o(du_we), .du_adr_o(du_adr), .du_dat_o(du_dat_to_cpu),
      .du_stall_o(du_stall)
   );

   trace_fifo u_trace (
      .clk_i(clk_i), .rst_i(rst_i),
      .push_valid_i(push_valid), .push_rec_i(push_rec), .push_ready_o(push_ready),
      .pop_valid_o(trace_valid_o), .pop_rec_o(trace_rec), .pop_ready_i(trace_ready_i)
   );

   // Flat trace vector
   assign trace_o[`TRACE_EXEC_ENABLE_MSB]                        = trace_valid_o;
   assign trace_o[`TRACE_EXEC_PC_MSB:`TRACE_EXEC_PC_LSB]         = trace_rec.pc;
   assign trace_o[`TRACE_EXEC_INSN_MSB:`TRACE_EXEC_INSN_LSB]     = trace_rec.insn;
   assign trace_o[`TRACE_EXEC_WBEN_MSB]                          = trace_rec.wben;
   assign trace_o[`TRACE_EXEC_WBREG_MSB:`TRACE_EXEC_WBREG_LSB]   = trace_rec.wbreg;
   assign trace_o[`TRACE_EXEC_WBDATA_MSB:`TRACE_EXEC_WBDATA_LSB] = trace_rec.wbdata;

endmodule

// ==== rtl/trace_fifo.sv ====
`timescale 1ns/1ns
`include "tile_defines.svh"

module trace_fifo (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 push_valid_i,
   input  tile_pkg::trace_rec_t push_rec_i,
   output logic                 push_ready_o,
   output logic                 pop_valid_o,
   output tile_pkg::trace_rec_t pop_rec_o,
   input  logic                 pop_ready_i
);

   import tile_pkg::*;

   localparam int PTR_W = $clog2(`TRACE_DEPTH);
   localparam int CNT_W = $clog2(`TRACE_DEPTH + 1);

   trace_rec_t       mem_q [`TRACE_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(`TRACE_DEPTH - 1)) ? '0 : p + 1'b1;   // Wrap at depth
   endfunction

   assign push_ready_o = (count_q != CNT_W'(`TRACE_DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign pop_rec_o    = mem_q[rd_ptr_q];
   assign push         = push_valid_i && push_ready_o;
   assign pop          = pop_valid_o && pop_ready_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= push_rec_i;
      end
   end

   // Refused push is held while the full FIFO has wrapped onto its head
   a_no_push_full : assert property (@(posedge clk_i) disable iff (rst_i)
      push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_rec_i)
         && $past(wr_ptr_q) == $past(rd_ptr_q));

endmodule

// ==== rtl/du_apb.sv ====
`timescale 1ns/1ns
`include "tile_defines.svh"

module du_apb (
   input  logic        clk_i,
   input  logic        rst_i,
   // APB slave
   input  logic        apb_psel_i,
   input  logic        apb_penable_i,
   input  logic        apb_pwrite_i,
   input  logic [11:0] apb_paddr_i,
   input  logic [31:0] apb_pwdata_i,
   output logic [31:0] apb_prdata_o,
   output logic        apb_pready_o,
   output logic        apb_pslverr_o,
   // Core debug port
   input  logic [31:0] du_dat_i,
   input  logic        du_ack_i,
   input  logic        du_halted_i,
   output logic        du_stb_o,
   output logic        du_we_o,
   output logic [3:0]  du_adr_o,
   output logic [31:0] du_dat_o,
   output logic        du_stall_o
);

   logic        stall_q;
   logic        busy_q;     // Strobe sent, waiting ack
   logic        access;
   logic [11:0] gpr_off;
   logic        hit_ctrl;
   logic        hit_pc;
   logic        hit_gpr;
   logic        hit_core;

   assign access   = apb_psel_i && apb_penable_i;   // Access phase
   assign gpr_off  = apb_paddr_i - `DBG_ADR_GPR_BASE;
   assign hit_ctrl = (apb_paddr_i == `DBG_ADR_CTRL);
   assign hit_pc   = (apb_paddr_i == `DBG_ADR_PC);
   assign hit_gpr  = (gpr_off[11:5] == 7'd0) && (gpr_off[1:0] == 2'b00);
   assign hit_core = hit_pc || hit_gpr;

   assign du_adr_o   = hit_pc ? 4'd8 : {1'b0, gpr_off[4:2]};
   assign du_we_o    = apb_pwrite_i;
   assign du_dat_o   = apb_pwdata_i;
   assign du_stall_o = stall_q;

   always_comb begin
      apb_pready_o  = 1'b0;
      apb_pslverr_o = 1'b0;
      apb_prdata_o  = '0;
      du_stb_o      = 1'b0;
      if (access) begin
         if (hit_ctrl) begin
            apb_pready_o = 1'b1;
            apb_prdata_o = {31'd0, du_halted_i}; // Halted status
         end else if (hit_core && (du_halted_i || busy_q)) begin
            du_stb_o     = !busy_q;              // One strobe per access
            apb_pready_o = du_ack_i;             // Wait states until core answers
            apb_prdata_o = du_dat_i;
         end else begin
            apb_pready_o  = 1'b1;                // Unmapped or core running
            apb_pslverr_o = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         stall_q <= 1'b0;
         busy_q  <= 1'b0;
      end else begin
         if (access && hit_ctrl && apb_pwrite_i) begin
            stall_q <= apb_pwdata_i[0];
         end
         if (du_stb_o) begin
            busy_q <= 1'b1;
         end else if (du_ack_i) begin
            busy_q <= 1'b0;
         end
      end
   end

   a_penable_psel : assert property (@(posedge clk_i) disable iff (rst_i)
      apb_penable_i |-> apb_psel_i);

   // Core stays halted across a pending debug access
   a_busy_halted : assert property (@(posedge clk_i) disable iff (rst_i)
      busy_q |-> du_halted_i);

endmodule

// ==== rtl/mini_core.sv ====
`timescale 1ns/1ns
`include "tile_defines.svh"

module mini_core (
   input  logic                 clk_i,
   input  logic                 rst_i,
   // Instruction Wishbone
   output logic                 iwb_cyc_o,
   output logic                 iwb_stb_o,
   output logic [31:0]          iwb_adr_o,
   input  logic                 iwb_ack_i,
   input  logic [31:0]          iwb_dat_i,
   // Data Wishbone
   output logic                 dwb_cyc_o,
   output logic                 dwb_stb_o,
   output logic                 dwb_we_o,
   output logic [31:0]          dwb_adr_o,
   output logic [31:0]          dwb_dat_o,
   input  logic                 dwb_ack_i,
   input  logic [31:0]          dwb_dat_i,
   // Debug port
   input  logic                 du_stb_i,
   input  logic                 du_we_i,
   input  logic [3:0]           du_adr_i,   // 0..7 GPR, 8 PC
   input  logic [31:0]          du_dat_i,
   input  logic                 du_stall_i,
   output logic [31:0]          du_dat_o,
   output logic                 du_ack_o,
   output logic                 du_halted_o,
   // Trace push
   output logic                 push_valid_o,
   output tile_pkg::trace_rec_t push_rec_o,
   input  logic                 push_ready_i
);

   import tile_pkg::*;

   core_state_e state_q;
   logic [31:0] pc_q;
   logic [31:0] gpr [8];       // r0 never written
   logic        iwb_cyc_q;
   logic        dwb_cyc_q;
   logic        du_ack_q;

   logic [31:0] insn_q;        // Fetched word
   logic [31:0] next_pc_q;     // PC after retire
   logic        wben_q;
   logic [31:0] wbdata_q;
   logic        dwb_we_q;
   logic [31:0] dwb_adr_q;
   logic [31:0] dwb_dat_q;
   logic [31:0] du_dat_q;

   opcode_e     op;
   logic [2:0]  rd;
   logic [2:0]  ra;
   logic [2:0]  rb;
   logic [31:0] ra_val;
   logic [31:0] rb_val;
   logic [31:0] imm_sext;

   assign op       = opcode_e'(insn_q[`INSN_OP_MSB:`INSN_OP_LSB]);
   assign rd       = insn_q[`INSN_RD_MSB:`INSN_RD_LSB];
   assign ra       = insn_q[`INSN_RA_MSB:`INSN_RA_LSB];
   assign rb       = insn_q[`INSN_RB_MSB:`INSN_RB_LSB];
   assign ra_val   = gpr[ra];
   assign rb_val   = gpr[rb];
   assign imm_sext = {{16{insn_q[`INSN_IMM_MSB]}}, insn_q[`INSN_IMM_MSB:`INSN_IMM_LSB]};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q   <= FETCH;
         pc_q      <= '0;
         iwb_cyc_q <= 1'b0;
         dwb_cyc_q <= 1'b0;
         du_ack_q  <= 1'b0;
         for (int i = 0; i < 8; i++) begin
            gpr[i] <= '0;
         end
      end else begin
         du_ack_q <= 1'b0;                         // Single cycle ack
         case (state_q)
            FETCH: begin
               if (!iwb_cyc_q) begin
                  iwb_cyc_q <= 1'b1;                // Launch fetch
               end else if (iwb_ack_i) begin
                  iwb_cyc_q <= 1'b0;
                  state_q   <= EXEC;
               end
            end
            EXEC: begin
               if (op == LW || op == SW) begin
                  dwb_cyc_q <= 1'b1;
                  state_q   <= MEM;
               end else begin
                  state_q <= RETIRE;
               end
            end
            MEM: begin
               if (dwb_ack_i) begin
                  dwb_cyc_q <= 1'b0;
                  state_q   <= RETIRE;
               end
            end
            RETIRE: begin
               if (push_ready_i) begin                // Record taken by FIFO
                  pc_q <= next_pc_q;
                  if (wben_q && rd != 3'd0) begin
                     gpr[rd] <= wbdata_q;
                  end
                  state_q <= du_stall_i ? HALT : FETCH;
               end
            end
            HALT: begin
               if (du_stb_i) begin
                  du_ack_q <= 1'b1;
                  if (du_we_i && du_adr_i[3]) begin
                     pc_q <= du_dat_i;
                  end else if (du_we_i && du_adr_i[2:0] != 3'd0) begin
                     gpr[du_adr_i[2:0]] <= du_dat_i;
                  end
               end else if (!du_stall_i) begin
                  state_q <= FETCH;                 // Resume at current PC
               end
            end
            default: state_q <= FETCH;
         endcase
      end
   end

   // Datapath registers
   always_ff @(posedge clk_i) begin
      if (state_q == FETCH && iwb_cyc_q && iwb_ack_i) begin
         insn_q <= iwb_dat_i;
      end
      if (state_q == EXEC) begin
         next_pc_q <= pc_q + 32'd4;
         wben_q    <= 1'b0;
         wbdata_q  <= '0;
         dwb_adr_q <= ra_val + imm_sext;
         dwb_we_q  <= (op == SW);
         dwb_dat_q <= rb_val;
         case (op)
            ADDI: begin
               wben_q   <= 1'b1;
               wbdata_q <= ra_val + imm_sext;
            end
            ADD: begin
               wben_q   <= 1'b1;
               wbdata_q <= ra_val + rb_val;
            end
            SUB: begin
               wben_q   <= 1'b1;
               wbdata_q <= ra_val - rb_val;
            end
            LW: begin
               wben_q <= 1'b1;                      // Data from MEM
            end
            BNE: begin
               if (ra_val != rb_val) begin
                  next_pc_q <= pc_q + (imm_sext << 2);
               end
            end
            default: begin
            end
         endcase
      end
      if (state_q == MEM && dwb_ack_i && !dwb_we_q) begin
         wbdata_q <= dwb_dat_i;                     // Load result
      end
      if (state_q == HALT && du_stb_i) begin
         du_dat_q <= du_adr_i[3] ? pc_q : gpr[du_adr_i[2:0]];
      end
   end

   assign iwb_cyc_o    = iwb_cyc_q;
   assign iwb_stb_o    = iwb_cyc_q;
   assign iwb_adr_o    = pc_q;                      // Held until retire
   assign dwb_cyc_o    = dwb_cyc_q;
   assign dwb_stb_o    = dwb_cyc_q;
   assign dwb_we_o     = dwb_we_q;
   assign dwb_adr_o    = dwb_adr_q;
   assign dwb_dat_o    = dwb_dat_q;
   assign du_dat_o     = du_dat_q;
   assign du_ack_o     = du_ack_q;
   assign du_halted_o  = (state_q == HALT);
   assign push_valid_o = (state_q == RETIRE);
   assign push_rec_o   = '{pc: pc_q, insn: insn_q, wben: wben_q, wbreg: rd, wbdata: wbdata_q};

   a_dwb_stb_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
      dwb_stb_o |-> dwb_cyc_o && state_q == MEM);

   a_dwb_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      dwb_stb_o && !dwb_ack_i |=> dwb_stb_o && $stable(dwb_adr_o) && $stable(dwb_we_o));

   a_iwb_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      iwb_stb_o && !iwb_ack_i |=> iwb_stb_o && $stable(iwb_adr_o));

   // Debug answers only come while halted
   a_du_ack_halt : assert property (@(posedge clk_i) disable iff (rst_i)
      du_ack_o |-> du_halted_o && $past(du_stb_i));

endmodule

// ==== rtl/tile_pkg.sv ====
package tile_pkg;

   // Opcode field, anything not listed retires as NOP
   typedef enum logic [3:0] {
      ADDI = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      LW   = 4'd3,
      SW   = 4'd4,   // Stores rb
      BNE  = 4'd5
   } opcode_e;

   typedef enum logic [2:0] {
      FETCH,         // Waiting for instruction ack
      EXEC,          // Decode and compute
      MEM,           // Waiting for data ack
      RETIRE,        // Pushing trace record
      HALT           // Stalled by debug unit
   } core_state_e;

   // One retired instruction
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [2:0]  wbreg;
      logic [31:0] wbdata;
   } trace_rec_t;

endpackage

// ==== include/tile_defines.svh ====
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Flat trace vector, write-back data in the low bits
`define TRACE_EXEC_WIDTH       101
`define TRACE_EXEC_ENABLE_MSB  100
`define TRACE_EXEC_PC_MSB      99
`define TRACE_EXEC_PC_LSB      68
`define TRACE_EXEC_INSN_MSB    67
`define TRACE_EXEC_INSN_LSB    36
`define TRACE_EXEC_WBEN_MSB    35
`define TRACE_EXEC_WBREG_MSB   34
`define TRACE_EXEC_WBREG_LSB   32
`define TRACE_EXEC_WBDATA_MSB  31
`define TRACE_EXEC_WBDATA_LSB  0

`define TRACE_DEPTH            4      // Trace FIFO entries

// Debug unit APB map
`define DBG_ADR_GPR_BASE       12'h000 // GPR n at base + 4*n
`define DBG_ADR_PC             12'h100
`define DBG_ADR_CTRL           12'h104 // Bit 0 stall, reads halted

// Instruction word fields
`define INSN_OP_MSB            31
`define INSN_OP_LSB            28
`define INSN_RD_MSB            27
`define INSN_RD_LSB            25
`define INSN_RA_MSB            24
`define INSN_RA_LSB            22
`define INSN_RB_MSB            21
`define INSN_RB_LSB            19
`define INSN_IMM_MSB           15
`define INSN_IMM_LSB           0

`endif
